// ==== Makefile ====
# Verilator build and run of the divide/sqrt testbench
VERILATOR ?= verilator
TOP       ?= tb_divsqrt
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: sim clean

# Status comes from the search for the pass line in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "TEST OK" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/divsqrt_consts.svh ====
// Datapath width, tag width, iteration count and narrow format widths
`ifndef DIVSQRT_CONSTS_SVH
`define DIVSQRT_CONSTS_SVH

// Operand and result width of the widest format
`define DS_WIDTH 32

// Request tag width
`define DS_TAG_W 4

// Engine iterations, one quotient bit each
`define DS_ITERS 32

// Narrow format widths
`define DS_FMT_W16 16
`define DS_FMT_W8  8

// Root needs only half the iterations, the rest is idle padding
// so both operations share one fixed latency

`endif

// ==== hw/divsqrt_ctrl.sv ====
// IDLE/BUSY/HOLD control FSM, stalled-result hold register and result boxing
`timescale 1ns/100ps
`include "divsqrt_consts.svh"

module divsqrt_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      flush_i,
  // Request side, from input stage
  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  output logic                      op_start_o,     // Accepted, one cycle
  // Latched info from issue registers
  input  divsqrt_pkg::fmt_e         fmt_i,
  input  divsqrt_pkg::tag_t         tag_i,
  // Engine result
  input  logic                      eng_done_i,
  input  logic [`DS_WIDTH-1:0]      eng_quot_i,
  input  logic                      eng_div_zero_i,
  // Response side, to output stage
  output logic                      rsp_valid_o,
  input  logic                      rsp_ready_i,
  output divsqrt_pkg::rsp_payload_t rsp_o,
  output logic                      busy_o
);
  import divsqrt_pkg::*;

  typedef enum logic [1:0] {IDLE, BUSY, HOLD} state_e;

  state_e       state_q, state_d;
  logic         req_ready;
  logic         rsp_valid;
  logic         busy;
  logic         hold_en;
  rsp_payload_t rsp_d;
  rsp_payload_t hold_q;

  // Live response, narrow results boxed with ones
  assign rsp_d.result   = eng_quot_i | ~fmt_mask(fmt_i);
  assign rsp_d.div_zero = eng_div_zero_i;
  assign rsp_d.tag      = tag_i;

  // ------------------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------------------
  always_comb begin
    state_d   = state_q;
    req_ready = 1'b0;
    rsp_valid = 1'b0;
    busy      = 1'b0;
    unique case (state_q)
      IDLE: begin
        req_ready = 1'b1;                     // Engine free
        if (req_valid_i) state_d = BUSY;
      end
      BUSY: begin
        busy = 1'b1;
        if (eng_done_i) begin
          rsp_valid = 1'b1;                   // Offer straight from the engine
          if (rsp_ready_i) begin
            req_ready = 1'b1;                 // Back to back issue allowed
            state_d   = req_valid_i ? BUSY : IDLE;
          end else begin
            state_d = HOLD;                   // Park it
          end
        end
      end
      HOLD: begin
        busy      = 1'b1;
        rsp_valid = 1'b1;
        if (rsp_ready_i) begin
          req_ready = 1'b1;
          state_d   = req_valid_i ? BUSY : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
    // Flush overrides everything
    if (flush_i) begin
      rsp_valid = 1'b0;
      busy      = 1'b0;
      state_d   = IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) state_q <= IDLE;
    else          state_q <= state_d;
  end

  // Hold register for a result downstream did not take
  assign hold_en = (state_q == BUSY) & eng_done_i & ~rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (hold_en) hold_q <= rsp_d;
  end

  assign op_start_o  = req_valid_i & req_ready & ~flush_i;
  assign req_ready_o = req_ready;
  assign rsp_valid_o = rsp_valid;
  assign rsp_o       = (state_q == HOLD) ? hold_q : rsp_d;  // Parked result first
  assign busy_o      = busy;

  // Engine only finishes what this FSM started
  a_done_in_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    eng_done_i |-> state_q == BUSY);

endmodule

// ==== hw/divsqrt_issue_regs.sv ====
// Issue registers with operand masking and the delayed engine start pulse
`timescale 1ns/100ps
`include "divsqrt_consts.svh"

module divsqrt_issue_regs (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      flush_i,
  input  logic                      op_start_i,   // One-cycle accept pulse from ctrl
  input  divsqrt_pkg::req_payload_t req_i,
  output logic                      eng_start_o,  // op_start_i delayed by one cycle
  output divsqrt_pkg::op_e          op_o,
  output divsqrt_pkg::fmt_e         fmt_o,
  output logic [`DS_WIDTH-1:0]      opa_o,
  output logic [`DS_WIDTH-1:0]      opb_o,
  output divsqrt_pkg::tag_t         tag_o
);
  import divsqrt_pkg::*;

  logic [`DS_WIDTH-1:0] live_mask;
  logic                 start_q;
  op_e                  op_q;
  fmt_e                 fmt_q;
  logic [`DS_WIDTH-1:0] opa_q;
  logic [`DS_WIDTH-1:0] opb_q;
  tag_t                 tag_q;

  assign live_mask = fmt_mask(req_i.fmt);  // Narrow formats drop their upper bits

  // ------------------------------------------------------------------------
  // Operation latch
  // ------------------------------------------------------------------------
  // Held for the whole run, ctrl reads fmt and tag again when boxing
  always_ff @(posedge clk_i) begin
    if (op_start_i) begin
      op_q  <= req_i.op;
      fmt_q <= req_i.fmt;
      opa_q <= req_i.opa & live_mask;
      opb_q <= req_i.opb & live_mask;
      tag_q <= req_i.tag;
    end
  end

  // Start pulse, one cycle after issue
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      start_q <= 1'b0;
    end else if (flush_i) begin
      start_q <= 1'b0;           // Pending start is cancelled
    end else begin
      start_q <= op_start_i;
    end
  end

  assign eng_start_o = start_q;
  assign op_o        = op_q;
  assign fmt_o       = fmt_q;
  assign opa_o       = opa_q;
  assign opb_o       = opb_q;
  assign tag_o       = tag_q;

endmodule

// ==== hw/divsqrt_iter_engine.sv ====
// Iterative radix-2 restoring divider and integer square root engine
`timescale 1ns/100ps
`include "divsqrt_consts.svh"

module divsqrt_iter_engine (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,      // Aborts a running operation
  input  logic                 start_i,
  input  divsqrt_pkg::op_e     op_i,
  input  logic [`DS_WIDTH-1:0] opa_i,        // Dividend or radicand, pre-masked
  input  logic [`DS_WIDTH-1:0] opb_i,        // Divisor, pre-masked
  output logic                 done_o,       // Pulse, DS_ITERS+1 cycles after start
  output logic                 busy_o,
  output logic [`DS_WIDTH-1:0] quot_o,
  output logic                 div_zero_o
);
  import divsqrt_pkg::*;

  localparam int unsigned      W          = `DS_WIDTH;
  localparam int unsigned      CNT_W      = $clog2(`DS_ITERS);
  localparam logic [CNT_W-1:0] LAST_CNT   = CNT_W'(`DS_ITERS - 1);
  localparam logic [CNT_W-1:0] SQRT_STEPS = CNT_W'(`DS_ITERS / 2);  // Two radicand bits/step

  // Control state
  logic             busy_q;
  logic             done_q;
  logic [CNT_W-1:0] cnt_q;
  // Datapath, no reset
  op_e              op_q;
  logic [W-1:0]     rem_q;     // Partial remainder
  logic [W-1:0]     dvd_q;     // Dividend/radicand, shifted out MSB first
  logic [W-1:0]     den_q;     // Divisor
  logic [W-1:0]     quot_q;    // Quotient or root, built LSB in
  logic             dz_q;

  logic             div_mode;
  logic [W+1:0]     partial;
  logic [W+1:0]     subtr;
  logic [W+2:0]     diff;      // Top bit is the borrow
  logic             take;
  logic             step_en;

  // ------------------------------------------------------------------------
  // Shared shift-subtract step
  // ------------------------------------------------------------------------
  assign div_mode = (op_q == DIV);
  assign partial  = div_mode ? {1'b0, rem_q, dvd_q[W-1]}    // Bring down one bit
                             : {rem_q, dvd_q[W-1:W-2]};     // Bring down two bits
  assign subtr    = div_mode ? {2'b00, den_q}
                             : {quot_q, 2'b01};             // Trial 4*root+1
  assign diff     = {1'b0, partial} - {1'b0, subtr};
  assign take     = ~diff[W+2];                             // No borrow, keep difference

  // Root is finished after half the count, then the datapath just waits
  assign step_en = busy_q & (div_mode | (cnt_q < SQRT_STEPS));

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q   <= op_i;
      dvd_q  <= opa_i;
      den_q  <= opb_i;
      rem_q  <= '0;
      quot_q <= '0;
      dz_q   <= (op_i == DIV) && (opb_i == '0);  // Quotient becomes all ones by itself
    end else if (step_en) begin
      rem_q  <= take ? diff[W-1:0] : partial[W-1:0];
      dvd_q  <= div_mode ? {dvd_q[W-2:0], 1'b0} : {dvd_q[W-3:0], 2'b00};
      quot_q <= {quot_q[W-2:0], take};
    end
  end

  // ------------------------------------------------------------------------
  // Iteration counter and status
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (flush_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      done_q <= 1'b0;
      cnt_q  <= '0;
    end else if (busy_q) begin
      cnt_q <= cnt_q + 1'b1;
      if (cnt_q == LAST_CNT) begin    // Last iteration lands this edge
        busy_q <= 1'b0;
        done_q <= 1'b1;
      end
    end else begin
      done_q <= 1'b0;                 // Done is a single pulse
    end
  end

  assign done_o     = done_q;
  assign busy_o     = busy_q;
  assign quot_o     = quot_q;
  assign div_zero_o = dz_q;

  // Issue logic only releases the engine once the previous run has ended
  a_no_start_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    start_i |-> !busy_o);

endmodule

// ==== hw/divsqrt_pipe_stage.sv ====
// Single valid/ready register stage with a type-parameter payload and flush
`timescale 1ns/100ps

module divsqrt_pipe_stage #(
  parameter type payload_t = divsqrt_pkg::req_payload_t
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,     // Drops whatever the stage holds
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Advance when downstream takes the item or the stage is only a bubble
  assign ready_o = ready_i | ~valid_q;

  // Valid bit, flush wins over a new load
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;        // Bubble in if nothing offered
    end
  end

  // Payload register, loads only on a real transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

  // A stalled item stays offered and unchanged until taken or flushed
  a_stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i && !flush_i |=> valid_o && $stable(data_o));

endmodule

// ==== hw/divsqrt_pkg.sv ====
// Operation, format, tag and payload types plus the format mask helper
`include "divsqrt_consts.svh"

package divsqrt_pkg;

  typedef enum logic {DIV = 1'b0, SQRT = 1'b1} op_e;       // Unsigned a/b or floor(sqrt(a))

  typedef enum logic [1:0] {FMT32 = 2'd0, FMT16 = 2'd1, FMT8 = 2'd2} fmt_e;

  typedef logic [`DS_TAG_W-1:0] tag_t;                     // Opaque request id

  // Request as it travels through the input stage, 71 bits
  typedef struct packed {
    op_e                  op;
    fmt_e                 fmt;
    logic [`DS_WIDTH-1:0] opa;                             // Dividend or radicand
    logic [`DS_WIDTH-1:0] opb;                             // Divisor, unused for root
    tag_t                 tag;
  } req_payload_t;

  // Response as it travels through the output stage, 37 bits
  typedef struct packed {
    logic [`DS_WIDTH-1:0] result;                          // Already boxed
    logic                 div_zero;
    tag_t                 tag;
  } rsp_payload_t;

  // Ones on the live bits of a format, zeros above
  function automatic logic [`DS_WIDTH-1:0] fmt_mask(fmt_e fmt);
    logic [`DS_WIDTH-1:0] mask;
    unique case (fmt)
      FMT16:   mask = {{(`DS_WIDTH-`DS_FMT_W16){1'b0}}, {`DS_FMT_W16{1'b1}}};
      FMT8:    mask = {{(`DS_WIDTH-`DS_FMT_W8){1'b0}}, {`DS_FMT_W8{1'b1}}};
      default: mask = '1;                                  // Full width
    endcase
    return mask;
  endfunction

endpackage

// ==== hw/divsqrt_top.sv ====
// Top level of the divide/sqrt unit: input stage, control, issue, engine, output stage
`timescale 1ns/100ps
`include "divsqrt_consts.svh"

module divsqrt_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  // Request
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  divsqrt_pkg::op_e     op_i,
  input  divsqrt_pkg::fmt_e    fmt_i,
  input  logic [`DS_WIDTH-1:0] opa_i,
  input  logic [`DS_WIDTH-1:0] opb_i,
  input  divsqrt_pkg::tag_t    tag_i,
  // Response
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [`DS_WIDTH-1:0] result_o,
  output logic                 div_zero_o,
  output divsqrt_pkg::tag_t    tag_o,
  output logic                 busy_o       // Anything in flight
);
  import divsqrt_pkg::*;

  req_payload_t         in_req, req_q;
  rsp_payload_t         rsp_d, rsp_q;
  logic                 req_valid, req_ready, op_start;
  logic                 rsp_valid, rsp_ready, ctrl_busy;
  logic                 eng_start, eng_done, eng_div_zero;
  op_e                  iss_op;
  fmt_e                 iss_fmt;
  tag_t                 iss_tag;
  logic [`DS_WIDTH-1:0] iss_opa, iss_opb, eng_quot;

  assign in_req = '{op: op_i, fmt: fmt_i, opa: opa_i, opb: opb_i, tag: tag_i};

  divsqrt_pipe_stage #(.payload_t(req_payload_t)) i_in_stage (
    .clk_i, .rst_n_i, .flush_i,
    .valid_i (in_valid_i), .ready_o (in_ready_o), .data_i (in_req),
    .valid_o (req_valid),  .ready_i (req_ready),  .data_o (req_q)
  );

  divsqrt_ctrl i_ctrl (
    .clk_i, .rst_n_i, .flush_i,
    .req_valid_i (req_valid), .req_ready_o (req_ready), .op_start_o (op_start),
    .fmt_i (iss_fmt), .tag_i (iss_tag),
    .eng_done_i (eng_done), .eng_quot_i (eng_quot), .eng_div_zero_i (eng_div_zero),
    .rsp_valid_o (rsp_valid), .rsp_ready_i (rsp_ready), .rsp_o (rsp_d), .busy_o (ctrl_busy)
  );

  divsqrt_issue_regs i_issue_regs (
    .clk_i, .rst_n_i, .flush_i,
    .op_start_i (op_start), .req_i (req_q), .eng_start_o (eng_start),
    .op_o (iss_op), .fmt_o (iss_fmt), .opa_o (iss_opa), .opb_o (iss_opb), .tag_o (iss_tag)
  );

  // Engine busy is covered by ctrl busy, left open here
  divsqrt_iter_engine i_iter_engine (
    .clk_i, .rst_n_i, .flush_i,
    .start_i (eng_start), .op_i (iss_op), .opa_i (iss_opa), .opb_i (iss_opb),
    .done_o (eng_done), .busy_o (), .quot_o (eng_quot), .div_zero_o (eng_div_zero)
  );

  divsqrt_pipe_stage #(.payload_t(rsp_payload_t)) i_out_stage (
    .clk_i, .rst_n_i, .flush_i,
    .valid_i (rsp_valid),   .ready_o (rsp_ready),   .data_i (rsp_d),
    .valid_o (out_valid_o), .ready_i (out_ready_i), .data_o (rsp_q)
  );

  assign result_o   = rsp_q.result;
  assign div_zero_o = rsp_q.div_zero;
  assign tag_o      = rsp_q.tag;
  assign busy_o     = req_valid | ctrl_busy | out_valid_o;

endmodule

// ==== testbench/tb_clock_gen.sv ====
// Testbench clock source and synchronous active-low reset pulse
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;  // 50 % duty
  end

  // Release on a falling edge, clear of the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// ==== testbench/tb_divsqrt.sv ====
// Testbench for divsqrt_top: stimulus table, LCG requests, reference model, checks, timeout
`timescale 1ns/100ps
`include "divsqrt_consts.svh"

module tb_divsqrt;
  import divsqrt_pkg::*;

  localparam int          CLK_PERIOD = 40;
  localparam int          SAMPLE_DLY = CLK_PERIOD / 4;   // Middle of the low phase
  localparam int          TABLE_N    = 12;
  localparam int          RAND_N     = 40;
  localparam int          HOLD_N     = 3;                // Out stage, hold register, in stage
  localparam int          FLUSH_N    = 2;                // Flushed request plus the one after
  localparam int          REQ_N      = TABLE_N + RAND_N + HOLD_N + FLUSH_N;
  localparam int          TIMEOUT    = REQ_N * (`DS_ITERS + 12) * 2;
  localparam logic [31:0] SEED       = 32'h317e_8068;

  // One directed request with its hand-worked answer
  typedef struct packed {
    op_e                  op;
    fmt_e                 fmt;
    logic [`DS_WIDTH-1:0] a;
    logic [`DS_WIDTH-1:0] b;
    tag_t                 tag;
    logic [`DS_WIDTH-1:0] exp_res;
    logic                 exp_dz;
  } vec_t;

  typedef struct packed {
    logic [`DS_WIDTH-1:0] res;
    logic                 dz;
    tag_t                 tag;
  } rsp_t;

  logic                 clk, rst_n, flush;
  logic                 in_valid, in_ready, out_valid, out_ready, out_dz, busy;
  op_e                  in_op;
  fmt_e                 in_fmt;
  logic [`DS_WIDTH-1:0] in_a, in_b, out_result;
  tag_t                 in_tag, out_tag;

  vec_t                 vectors [TABLE_N];
  rsp_t                 exp_q [$];           // Responses still owed, oldest first
  string                name_q [$];
  int                   errors;
  int                   checks;
  int                   cycle_cnt = 0;
  logic                 bp_en;               // Random out_ready when set
  logic                 bp_hold;             // Downstream held off when set
  logic [31:0]          req_state, bp_state;
  logic                 stalled;
  rsp_t                 stall_rsp;
  string                stall_name;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(2)) i_clock_gen (
    .clk_o (clk), .rst_n_o (rst_n)
  );

  divsqrt_top i_divsqrt_top (
    .clk_i (clk), .rst_n_i (rst_n), .flush_i (flush),
    .in_valid_i (in_valid), .in_ready_o (in_ready),
    .op_i (in_op), .fmt_i (in_fmt), .opa_i (in_a), .opb_i (in_b), .tag_i (in_tag),
    .out_valid_o (out_valid), .out_ready_i (out_ready),
    .result_o (out_result), .div_zero_o (out_dz), .tag_o (out_tag), .busy_o (busy)
  );

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;  // Numerical Recipes constants
  endfunction

  function automatic logic [`DS_WIDTH-1:0] width_mask(input fmt_e fmt);
    logic [`DS_WIDTH-1:0] mask;
    mask = '1;
    if (fmt == FMT16) mask = mask >> (`DS_WIDTH - `DS_FMT_W16);
    if (fmt == FMT8)  mask = mask >> (`DS_WIDTH - `DS_FMT_W8);
    return mask;
  endfunction

  // Largest r with r*r <= x, by bisection
  function automatic logic [31:0] int_sqrt(input logic [31:0] x);
    logic [63:0] lo;
    logic [63:0] hi;
    logic [63:0] mid;
    lo = 64'd0;
    hi = 64'd65536;                       // 65536^2 is above any 32-bit value
    while (hi - lo > 64'd1) begin
      mid = (lo + hi) >> 1;
      if (mid * mid <= {32'd0, x}) lo = mid;
      else                         hi = mid;
    end
    return lo[31:0];
  endfunction

  function automatic rsp_t ref_model(input op_e op, input fmt_e fmt, input logic [31:0] a,
                                     input logic [31:0] b, input tag_t tag);
    rsp_t        r;
    logic [31:0] mask;
    logic [31:0] ma;
    logic [31:0] mb;
    mask  = width_mask(fmt);
    ma    = a & mask;
    mb    = b & mask;
    r.tag = tag;
    r.dz  = 1'b0;
    if (op == SQRT) begin
      r.res = int_sqrt(ma);
    end else if (mb == 32'd0) begin
      r.res = mask;                       // All ones of the format
      r.dz  = 1'b1;
    end else begin
      r.res = ma / mb;
    end
    r.res = r.res | ~mask;                // Box narrow results
    return r;
  endfunction

  // --------------------------------------------------------------------------
  // Checks and drivers
  // --------------------------------------------------------------------------
  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_rsp();
    rsp_t  exp;
    string name;
    if (exp_q.size() == 0) begin
      errors++;
      $display("Unexpected response with tag %h while no request was outstanding", out_tag);
    end else begin
      exp  = exp_q.pop_front();
      name = name_q.pop_front();
      check_val({name, " result"}, exp.res, out_result);
      check_val({name, " div_zero"}, 32'(exp.dz), 32'(out_dz));
      check_val({name, " tag"}, 32'(exp.tag), 32'(out_tag));
    end
  endtask

  // Offer on a falling edge, hold until in_ready is seen high
  task automatic send_req(input op_e op, input fmt_e fmt, input logic [31:0] a,
                          input logic [31:0] b, input tag_t tag, input rsp_t exp,
                          input string name, input logic expect_rsp);
    @(negedge clk);
    in_valid = 1'b1;
    in_op    = op;
    in_fmt   = fmt;
    in_a     = a;
    in_b     = b;
    in_tag   = tag;
    #(SAMPLE_DLY);
    while (!in_ready) begin
      @(negedge clk);
      #(SAMPLE_DLY);
    end
    if (expect_rsp) begin               // Transfer lands on the coming rising edge
      exp_q.push_back(exp);
      name_q.push_back(name);
    end
  endtask

  task automatic idle_inputs();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_drain(input string name);
    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
    #(SAMPLE_DLY);
    check_val({name, " drained busy"}, 32'd0, 32'(busy));
    check_val({name, " drained in_ready"}, 32'd1, 32'(in_ready));
  endtask

  task automatic load_table();
    vectors[0]  = '{DIV,  FMT32, 32'd100,       32'd7,         4'h0, 32'h0000_000E, 1'b0};
    vectors[1]  = '{DIV,  FMT32, 32'hFFFF_FFFF, 32'd1,         4'h1, 32'hFFFF_FFFF, 1'b0};
    vectors[2]  = '{DIV,  FMT32, 32'h1234_5678, 32'h0000_1234, 4'h2, 32'h0001_0004, 1'b0};
    vectors[3]  = '{DIV,  FMT32, 32'd5,         32'd9,         4'h3, 32'h0000_0000, 1'b0};
    vectors[4]  = '{SQRT, FMT32, 32'hFFFF_FFFF, 32'd0,         4'h4, 32'h0000_FFFF, 1'b0};
    vectors[5]  = '{SQRT, FMT32, 32'd1000000,   32'd0,         4'h5, 32'h0000_03E8, 1'b0};
    vectors[6]  = '{DIV,  FMT16, 32'hABCD_1234, 32'h5555_0011, 4'h6, 32'hFFFF_0112, 1'b0};
    vectors[7]  = '{SQRT, FMT16, 32'hFFFF_FFFF, 32'd0,         4'h7, 32'hFFFF_00FF, 1'b0};
    vectors[8]  = '{DIV,  FMT8,  32'h1234_56F0, 32'hFFFF_FF0F, 4'h8, 32'hFFFF_FF10, 1'b0};
    vectors[9]  = '{SQRT, FMT8,  32'h0000_FF90, 32'd0,         4'h9, 32'hFFFF_FF0C, 1'b0};
    vectors[10] = '{DIV,  FMT32, 32'hDEAD_BEEF, 32'd0,         4'hA, 32'hFFFF_FFFF, 1'b1};
    vectors[11] = '{DIV,  FMT16, 32'h0000_0321, 32'h0001_0000, 4'hB, 32'hFFFF_FFFF, 1'b1};
  endtask

  // --------------------------------------------------------------------------
  // Output side: random back-pressure, response and stall checks
  // --------------------------------------------------------------------------
  initial begin
    out_ready = 1'b1;
    bp_state  = SEED ^ 32'h5a5a_a5a5;   // Own stream, apart from the requests
    stalled   = 1'b0;
    forever begin
      @(negedge clk);
      bp_state  = lcg_next(bp_state);
      out_ready = bp_hold ? 1'b0 : (bp_en ? bp_state[20] : 1'b1);
      #(SAMPLE_DLY);
      if (rst_n) begin
        if (stalled) begin              // Parked item must not move or change
          check_val({stall_name, " stalled valid"}, 32'd1, 32'(out_valid));
          check_val({stall_name, " stalled result"}, stall_rsp.res, out_result);
          check_val({stall_name, " stalled div_zero"}, 32'(stall_rsp.dz), 32'(out_dz));
          check_val({stall_name, " stalled tag"}, 32'(stall_rsp.tag), 32'(out_tag));
        end
        stalled = 1'b0;
        if (out_valid && out_ready) begin
          compare_rsp();
        end else if (out_valid) begin
          stalled   = 1'b1;
          stall_rsp = '{res: out_result, dz: out_dz, tag: out_tag};
          if (name_q.size() != 0) stall_name = name_q[0];
          else                    stall_name = "unexpected";
        end
        if (flush) stalled = 1'b0;      // Flush may drop it legally
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("Timeout after %0d cycles, responses stopped arriving", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    int          i;
    vec_t        v;
    logic [31:0] ra;
    logic [31:0] rb;
    logic [31:0] rc;
    op_e         op;
    fmt_e        fmt;
    in_valid  = 1'b0;
    in_op     = DIV;
    in_fmt    = FMT32;
    in_a      = '0;
    in_b      = '0;
    in_tag    = '0;
    flush     = 1'b0;
    bp_en     = 1'b0;
    bp_hold   = 1'b0;
    errors    = 0;
    checks    = 0;
    req_state = SEED;
    load_table();

    while (!rst_n) @(negedge clk);
    #(SAMPLE_DLY);
    check_val("reset busy", 32'd0, 32'(busy));
    check_val("reset in_ready", 32'd1, 32'(in_ready));
    check_val("reset out_valid", 32'd0, 32'(out_valid));

    // Directed table, downstream always ready
    for (i = 0; i < TABLE_N; i++) begin
      v = vectors[i];
      send_req(v.op, v.fmt, v.a, v.b, v.tag, '{res: v.exp_res, dz: v.exp_dz, tag: v.tag},
               $sformatf("table %0d", i), 1'b1);
    end
    idle_inputs();
    wait_drain("table");

    // LCG requests under random back-pressure
    bp_en = 1'b1;
    for (i = 0; i < RAND_N; i++) begin
      req_state = lcg_next(req_state);
      rc        = req_state;
      req_state = lcg_next(req_state);
      ra        = req_state;
      req_state = lcg_next(req_state);
      rb        = req_state >> rc[20:16];          // Spread of divisor sizes
      if (rc[23:21] == 3'd0) rb = '0;              // Some zero divisors
      op = rc[24] ? SQRT : DIV;
      case (rc[26:25])
        2'd1:    fmt = FMT16;
        2'd2:    fmt = FMT8;
        default: fmt = FMT32;
      endcase
      send_req(op, fmt, ra, rb, tag_t'(i), ref_model(op, fmt, ra, rb, tag_t'(i)),
               $sformatf("random %0d", i), 1'b1);
    end
    idle_inputs();
    wait_drain("random");
    bp_en = 1'b0;

    // Downstream held off, second result parks in the hold register
    bp_hold = 1'b1;
    for (i = 0; i < HOLD_N; i++) begin
      v = vectors[i + 4];
      send_req(v.op, v.fmt, v.a, v.b, v.tag, '{res: v.exp_res, dz: v.exp_dz, tag: v.tag},
               $sformatf("hold %0d", i), 1'b1);
    end
    idle_inputs();
    repeat (`DS_ITERS + 8) @(negedge clk);         // Second run ends under the stall
    #(SAMPLE_DLY);
    check_val("hold out_valid", 32'd1, 32'(out_valid));
    check_val("hold in_ready", 32'd0, 32'(in_ready));
    check_val("hold busy", 32'd1, 32'(busy));
    bp_hold = 1'b0;
    wait_drain("hold");

    // Flush in the middle of an engine run
    send_req(DIV, FMT32, 32'hF000_0000, 32'd3, 4'hF, '0, "flush victim", 1'b0);
    idle_inputs();
    repeat (8) @(negedge clk);                     // Well inside the iterations
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    #(SAMPLE_DLY);
    check_val("flush busy", 32'd0, 32'(busy));
    check_val("flush out_valid", 32'd0, 32'(out_valid));
    repeat (`DS_ITERS + 8) @(negedge clk);         // A leaked result would show up here
    send_req(SQRT, FMT16, 32'h1234_0E11, 32'd0, 4'h5,
             ref_model(SQRT, FMT16, 32'h1234_0E11, 32'd0, 4'h5), "after flush", 1'b1);
    idle_inputs();
    wait_drain("after flush");

    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected responses never arrived", exp_q.size());
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/divsqrt_pkg.sv
hw/divsqrt_pipe_stage.sv
hw/divsqrt_issue_regs.sv
hw/divsqrt_iter_engine.sv
hw/divsqrt_ctrl.sv
hw/divsqrt_top.sv
testbench/tb_clock_gen.sv
testbench/tb_divsqrt.sv
